// ==== logic/coreSettings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path width
`define CORE_XLEN 32

// Register tag width, 64 architectural registers
`define CORE_TAG_BITS 6

// Cycles from issue to register-file write, also the scoreboard countdown start
`define CORE_WB_DEPTH 3

// Immediate field width before sign extension
`define CORE_IMM_BITS 10

// Cycles to wait on a handshake edge before giving up
`define CORE_HS_TIMEOUT 200

`endif

// ==== logic/corePkg.sv ====
`include "coreSettings.svh"

package corePkg;

    // Opcode field, bits 31:28 of the instruction word
    typedef enum logic [3:0] {
        OpAdd   = 4'd0,
        OpSub   = 4'd1,
        OpAnd   = 4'd2,
        OpOr    = 4'd3,
        OpXor   = 4'd4,
        OpSll   = 4'd5,
        OpSrl   = 4'd6,
        OpAddi  = 4'd7,
        OpAuipc = 4'd8
    } Opcode;

    // Four-phase handshake on the instruction port
    typedef enum logic {
        HsIdle,
        HsWaitDrop
    } HandshakeState;

    // Decoded micro-op, decode to operand load
    typedef struct packed {
        logic                        valid;
        Opcode                       opcode;
        logic [`CORE_TAG_BITS-1:0]   tagDst;
        logic [`CORE_TAG_BITS-1:0]   tagA;
        logic [`CORE_TAG_BITS-1:0]   tagB;
        logic [`CORE_XLEN-1:0]       imm;
        logic [`CORE_XLEN-1:0]       pc;
        // Source readable from the register file this cycle
        logic                        availA;
        logic                        availB;
        // Source replaced by pc or immediate
        logic                        pcA;
        logic                        immB;
    } RUop;

    // Micro-op with both operands resolved, operand load to execute
    typedef struct packed {
        logic                        valid;
        Opcode                       opcode;
        logic [`CORE_TAG_BITS-1:0]   tagDst;
        logic [`CORE_XLEN-1:0]       srcA;
        logic [`CORE_XLEN-1:0]       srcB;
    } Uop;

    // Writeback broadcast from execute
    typedef struct packed {
        logic                        valid;
        logic [`CORE_TAG_BITS-1:0]   tag;
        logic [`CORE_XLEN-1:0]       result;
    } WbBus;

endpackage

// ==== logic/decode.sv ====
`timescale 1ns/10ps
`include "coreSettings.svh"

module decode (
    input  logic         clk,
    input  logic         rst,
    input  logic         req,
    input  logic [31:0]  instr,
    output logic         ack,
    output corePkg::RUop rUop
);
    import corePkg::*;

    localparam int CntBits = $clog2(`CORE_WB_DEPTH + 1);
    localparam int NumTags = 1 << `CORE_TAG_BITS;

    HandshakeState state;
    logic [`CORE_XLEN-1:0] pc;
    logic [CntBits-1:0] countdown [NumTags];

    Opcode opcode;
    logic [`CORE_TAG_BITS-1:0] tagDst;
    logic [`CORE_TAG_BITS-1:0] tagA;
    logic [`CORE_TAG_BITS-1:0] tagB;
    logic [`CORE_XLEN-1:0] imm;
    logic pcA;
    logic immB;
    logic stall;
    logic accept;

    // Field split, unused opcode encodings fall back to add
    always_comb begin
        if (instr[31:28] <= 4'(OpAuipc)) begin
            opcode = Opcode'(instr[31:28]);
        end else begin
            opcode = OpAdd;
        end
        tagDst = instr[27:22];
        tagA   = instr[21:16];
        tagB   = instr[15:10];
        imm    = {{(`CORE_XLEN - `CORE_IMM_BITS){instr[`CORE_IMM_BITS-1]}},
                  instr[`CORE_IMM_BITS-1:0]};
        pcA    = (opcode == OpAuipc);
        immB   = (opcode == OpAddi) || (opcode == OpAuipc);
    end

    // A producer issued last cycle can be neither read nor snooped in time
    always_comb begin
        stall = (!pcA && countdown[tagA] == CntBits'(`CORE_WB_DEPTH))
             || (!immB && countdown[tagB] == CntBits'(`CORE_WB_DEPTH));
        accept = (state == HsIdle) && req && !stall;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= HsIdle;
            ack        <= 1'b0;
            pc         <= '0;
            rUop.valid <= 1'b0;
            for (int t = 0; t < NumTags; t++) begin
                countdown[t] <= '0;
            end
        end else begin
            rUop.valid <= accept;

            for (int t = 0; t < NumTags; t++) begin
                if (countdown[t] != '0) begin
                    countdown[t] <= countdown[t] - 1'b1;
                end
            end
            // Issue overrides the decrement of its own destination
            if (accept) begin
                countdown[tagDst] <= CntBits'(`CORE_WB_DEPTH);
                rUop.opcode <= opcode;
                rUop.tagDst <= tagDst;
                rUop.tagA   <= tagA;
                rUop.tagB   <= tagB;
                rUop.imm    <= imm;
                rUop.pc     <= pc;
                rUop.pcA    <= pcA;
                rUop.immB   <= immB;
                // At most 1 left means the register file is written by the load cycle
                rUop.availA <= !pcA && (countdown[tagA] <= CntBits'(1));
                rUop.availB <= !immB && (countdown[tagB] <= CntBits'(1));
            end

            case (state)
                HsIdle: begin
                    if (accept) begin
                        ack   <= 1'b1;
                        pc    <= pc + `CORE_XLEN'(4);
                        state <= HsWaitDrop;
                    end
                end
                HsWaitDrop: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= HsIdle;
                    end
                end
                default: state <= HsIdle;
            endcase
        end
    end

    // Host must be requesting when ack goes up
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req));

    // One micro-op per handshake, issued with the ack edge
    uopOnAckRise: assert property (@(posedge clk) disable iff (rst)
        rUop.valid |-> $rose(ack));

endmodule

// ==== logic/operandLoad.sv ====
`timescale 1ns/10ps
`include "coreSettings.svh"

module operandLoad (
    input  logic                      clk,
    input  logic                      rst,
    input  corePkg::RUop              rUop,
    input  corePkg::WbBus             wb,
    output logic                      rfReadValidA,
    output logic                      rfReadValidB,
    output logic [`CORE_TAG_BITS-1:0] rfReadAddrA,
    output logic [`CORE_TAG_BITS-1:0] rfReadAddrB,
    input  logic [`CORE_XLEN-1:0]     rfReadDataA,
    input  logic [`CORE_XLEN-1:0]     rfReadDataB,
    output corePkg::Uop               uop
);
    import corePkg::*;

    logic hitA;
    logic hitB;
    logic [`CORE_XLEN-1:0] srcA;
    logic [`CORE_XLEN-1:0] srcB;

    // Only sources marked available go to the register file
    always_comb begin
        rfReadValidA = rUop.valid && rUop.availA;
        rfReadAddrA  = rUop.tagA;
        rfReadValidB = rUop.valid && rUop.availB;
        rfReadAddrB  = rUop.tagB;
    end

    // Producer finishing this very cycle
    always_comb begin
        hitA = wb.valid && (wb.tag == rUop.tagA);
        hitB = wb.valid && (wb.tag == rUop.tagB);
    end

    always_comb begin
        if (rUop.pcA) begin
            srcA = rUop.pc;
        end else if (rUop.availA) begin
            srcA = rfReadDataA;
        end else if (hitA) begin
            srcA = wb.result;
        end else begin
            srcA = '0;
        end

        if (rUop.immB) begin
            srcB = rUop.imm;
        end else if (rUop.availB) begin
            srcB = rfReadDataB;
        end else if (hitB) begin
            srcB = wb.result;
        end else begin
            srcB = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uop.valid <= 1'b0;
        end else begin
            uop.valid <= rUop.valid;
            if (rUop.valid) begin
                uop.opcode <= rUop.opcode;
                uop.tagDst <= rUop.tagDst;
                uop.srcA   <= srcA;
                uop.srcB   <= srcB;
            end
        end
    end

    // Decode's scoreboard promises the writeback bus carries any pending source
    snoopHitA: assert property (@(posedge clk) disable iff (rst)
        (rUop.valid && !rUop.pcA && !rUop.availA) |-> hitA);
    snoopHitB: assert property (@(posedge clk) disable iff (rst)
        (rUop.valid && !rUop.immB && !rUop.availB) |-> hitB);

endmodule

// ==== logic/execute.sv ====
`timescale 1ns/10ps
`include "coreSettings.svh"

module execute (
    input  logic          clk,
    input  logic          rst,
    input  corePkg::Uop   uop,
    output corePkg::WbBus wb
);
    import corePkg::*;

    logic [`CORE_XLEN-1:0] result;

    always_comb begin
        case (uop.opcode)
            OpSub:   result = uop.srcA - uop.srcB;
            OpAnd:   result = uop.srcA & uop.srcB;
            OpOr:    result = uop.srcA | uop.srcB;
            OpXor:   result = uop.srcA ^ uop.srcB;
            OpSll:   result = uop.srcA << uop.srcB[4:0];
            OpSrl:   result = uop.srcA >> uop.srcB[4:0];
            // Add, addi and auipc all sum the two sources
            default: result = uop.srcA + uop.srcB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= uop.valid;
            if (uop.valid) begin
                wb.tag    <= uop.tagDst;
                wb.result <= result;
            end
        end
    end

    // Decode maps every raw encoding onto a known opcode
    legalOpcode: assert property (@(posedge clk) disable iff (rst)
        uop.valid |-> uop.opcode inside {OpAdd, OpSub, OpAnd, OpOr, OpXor,
                                         OpSll, OpSrl, OpAddi, OpAuipc});

endmodule

// ==== logic/writeback.sv ====
`timescale 1ns/10ps
`include "coreSettings.svh"

module writeback (
    input  logic                      clk,
    input  logic                      rst,
    input  corePkg::WbBus             wb,
    input  logic                      rfReadValidA,
    input  logic                      rfReadValidB,
    input  logic [`CORE_TAG_BITS-1:0] rfReadAddrA,
    input  logic [`CORE_TAG_BITS-1:0] rfReadAddrB,
    output logic [`CORE_XLEN-1:0]     rfReadDataA,
    output logic [`CORE_XLEN-1:0]     rfReadDataB,
    output logic                      resultValid,
    output logic [`CORE_TAG_BITS-1:0] resultTag,
    output logic [`CORE_XLEN-1:0]     resultData
);
    import corePkg::*;

    localparam int NumRegs = 1 << `CORE_TAG_BITS;

    logic [`CORE_XLEN-1:0] regFile [NumRegs];

    // Asynchronous read, zero when no request
    always_comb begin
        rfReadDataA = rfReadValidA ? regFile[rfReadAddrA] : '0;
        rfReadDataB = rfReadValidB ? regFile[rfReadAddrB] : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NumRegs; r++) begin
                regFile[r] <= '0;
            end
        end else if (wb.valid) begin
            regFile[wb.tag] <= wb.result;
        end
    end

    // Retire trace, registered on the same edge as the write
    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= wb.valid;
            if (wb.valid) begin
                resultTag  <= wb.tag;
                resultData <= wb.result;
            end
        end
    end

    traceFollowsWb: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> $past(wb.valid));

endmodule

// ==== logic/coreTop.sv ====
`timescale 1ns/10ps
`include "coreSettings.svh"

module coreTop (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  logic [31:0]               instr,
    output logic                      ack,
    output logic                      resultValid,
    output logic [`CORE_TAG_BITS-1:0] resultTag,
    output logic [`CORE_XLEN-1:0]     resultData
);
    import corePkg::*;

    RUop  rUop;
    Uop   uop;
    WbBus wb;

    logic                      rfReadValidA;
    logic                      rfReadValidB;
    logic [`CORE_TAG_BITS-1:0] rfReadAddrA;
    logic [`CORE_TAG_BITS-1:0] rfReadAddrB;
    logic [`CORE_XLEN-1:0]     rfReadDataA;
    logic [`CORE_XLEN-1:0]     rfReadDataB;

    decode i_decode (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .instr (instr),
        .ack   (ack),
        .rUop  (rUop)
    );

    operandLoad i_operandLoad (
        .clk          (clk),
        .rst          (rst),
        .rUop         (rUop),
        .wb           (wb),
        .rfReadValidA (rfReadValidA),
        .rfReadValidB (rfReadValidB),
        .rfReadAddrA  (rfReadAddrA),
        .rfReadAddrB  (rfReadAddrB),
        .rfReadDataA  (rfReadDataA),
        .rfReadDataB  (rfReadDataB),
        .uop          (uop)
    );

    execute i_execute (
        .clk (clk),
        .rst (rst),
        .uop (uop),
        .wb  (wb)
    );

    writeback i_writeback (
        .clk          (clk),
        .rst          (rst),
        .wb           (wb),
        .rfReadValidA (rfReadValidA),
        .rfReadValidB (rfReadValidB),
        .rfReadAddrA  (rfReadAddrA),
        .rfReadAddrB  (rfReadAddrB),
        .rfReadDataA  (rfReadDataA),
        .rfReadDataB  (rfReadDataB),
        .resultValid  (resultValid),
        .resultTag    (resultTag),
        .resultData   (resultData)
    );

endmodule

// ==== testbench/coreTb.sv ====
`timescale 1ns/10ps
`include "coreSettings.svh"

module coreTb;

    localparam int unsigned RandSeed = 32'h8f7d610c;
    localparam int Timeout = `CORE_HS_TIMEOUT;

    // One line of the stimulus file
    typedef struct packed {
        logic [31:0]               word;
        logic [`CORE_TAG_BITS-1:0] tag;
        logic [`CORE_XLEN-1:0]     result;
    } TestEntry;

    // One observed retire strobe
    typedef struct packed {
        logic [31:0]               cycle;
        logic [`CORE_TAG_BITS-1:0] tag;
        logic [`CORE_XLEN-1:0]     data;
    } TraceEntry;

    logic                      clk;
    logic                      rst;
    logic                      req;
    logic [31:0]               instr;
    logic                      ack;
    logic                      resultValid;
    logic [`CORE_TAG_BITS-1:0] resultTag;
    logic [`CORE_XLEN-1:0]     resultData;

    TestEntry  entries[$];
    int        gaps[$];
    TraceEntry strobeQ[$];
    int        ackCycles[$];
    int        cycleCount;
    int        errorCount;
    int        failCount;
    bit        aborted;

    coreTop i_coreTop (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .instr       (instr),
        .ack         (ack),
        .resultValid (resultValid),
        .resultTag   (resultTag),
        .resultData  (resultData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial cycleCount = 0;
    always @(posedge clk) cycleCount <= cycleCount + 1;

    // Trace monitor, samples away from the active edge
    always @(negedge clk) begin
        if (resultValid === 1'b1) begin
            strobeQ.push_back({32'(cycleCount), resultTag, resultData});
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic loadTestdata();
        int fd;
        string line;
        logic [31:0] word;
        logic [31:0] tag;
        logic [31:0] result;
        int gap;
        fd = $fopen("testbench/coreTestdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file testbench/coreTestdata.txt");
            failCount++;
            aborted = 1'b1;
        end else begin
            while ($fgets(line, fd) > 0) begin
                // Comment lines do not parse as four fields
                if ($sscanf(line, "%h %h %h %d", word, tag, result, gap) == 4) begin
                    entries.push_back({word, tag[`CORE_TAG_BITS-1:0], result});
                    gaps.push_back(gap);
                end
            end
            $fclose(fd);
            if (entries.size() == 0) begin
                $display("The stimulus file holds no instructions");
                failCount++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic checkIdle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            checkValue("idle ack", 0, ack);
            checkValue("idle resultValid", 0, resultValid);
        end
    endtask

    task automatic waitAck(input logic level, input int index, output int waited);
        waited = 0;
        while (ack !== level && !aborted) begin
            @(negedge clk);
            waited++;
            if (waited > Timeout) begin
                $display("Timed out waiting for ack to go %0d on instruction %0d", level, index);
                failCount++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic waitStrobe(input int index, output bit got);
        int waited;
        waited = 0;
        got = 1'b0;
        while (!got && !aborted) begin
            if (strobeQ.size() > 0) begin
                got = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
                if (waited > Timeout) begin
                    $display("Timed out waiting for the trace strobe of instruction %0d", index);
                    failCount++;
                    aborted = 1'b1;
                end
            end
        end
    endtask

    // Host side of the four-phase handshake
    task automatic driveAll();
        int gap;
        int waited;
        for (int i = 0; i < entries.size() && !aborted; i++) begin
            gap = gaps[i];
            if (gap < 0) begin
                gap = $urandom_range(4, 0);
            end
            repeat (gap) @(negedge clk);
            instr = entries[i].word;
            req = 1'b1;
            waitAck(1'b1, i, waited);
            if (!aborted) begin
                ackCycles.push_back(cycleCount);
                req = 1'b0;
                waitAck(1'b0, i, waited);
                // Ack must drop on the first edge that sees req low
                checkValue($sformatf("instr %0d ack drop cycles", i), 1, waited);
            end
        end
        req = 1'b0;
    endtask

    task automatic checkTrace();
        TraceEntry s;
        bit got;
        int expectCycle;
        for (int i = 0; i < entries.size() && !aborted; i++) begin
            waitStrobe(i, got);
            if (got) begin
                s = strobeQ.pop_front();
                if (ackCycles.size() == 0) begin
                    $display("Trace strobe %0d arrived before its instruction was accepted", i);
                    failCount++;
                end else begin
                    expectCycle = ackCycles.pop_front() + `CORE_WB_DEPTH;
                    checkValue($sformatf("instr %0d latency", i), expectCycle, s.cycle);
                end
                checkValue($sformatf("instr %0d tag", i), entries[i].tag, s.tag);
                checkValue($sformatf("instr %0d result", i), entries[i].result, s.data);
            end
        end
    endtask

    initial begin
        errorCount = 0;
        failCount = 0;
        aborted = 1'b0;
        void'($urandom(RandSeed));
        rst = 1'b1;
        req = 1'b0;
        instr = '0;
        loadTestdata();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        checkIdle(5);
        fork
            driveAll();
            checkTrace();
        join

        // Pipeline drains, nothing more may retire
        repeat (10) @(negedge clk);
        if (!aborted && strobeQ.size() != 0) begin
            $display("%0d unexpected trace strobes after the last instruction", strobeQ.size());
            failCount++;
        end

        $display("Summary: %0d value mismatches, %0d other failures", errorCount, failCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/corePkg.sv
logic/decode.sv
logic/operandLoad.sv
logic/execute.sv
logic/writeback.sv
logic/coreTop.sv
testbench/coreTb.sv

// ==== testbench/coreTestdata.txt ====
// Columns: instruction word (hex), expected tag (hex), expected result (hex), gap (decimal)
// Gap is idle cycles before req rises, -1 picks a random gap
70400064 01 00000064 2
708003fd 02 fffffffd 1
70c001ff 03 000001ff 1
01010c00 04 00000263 0
11410800 05 00000067 3
11820400 06 ffffff99 1
21c20c00 07 000001fd 0
32011000 08 00000267 2
42430800 09 fffffe02 1
72800005 0a 00000005 1
52c12800 0b 00000c80 0
63022800 0c 07ffffff 2
534a1000 0d 00000028 1
83800010 0e 00000044 0
83c10bf8 0f 00000030 1
74040200 10 00000063 2
75100001 14 00000064 0
05545000 15 000000c8 0
15950400 16 00000064 0
45d65400 17 000000ac 0
56172800 18 00001580 0
36436000 19 000015ff 0
66992800 1a 000000af 0
26da2400 1b 00000002 0
f7010c00 1c 00000263 -1
70410001 01 00000065 -1
07416c00 1d 00000067 -1
878001ff 1e 0000026b -1
